//--- hdl/exec_pkg.sv
package exec_pkg;

	// ==================================================
	// widths
	// ==================================================
	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int SHAMT_W    = 5;
	// one quotient bit per iteration
	localparam int DIV_STEPS  = WORD_W;

	// ==================================================
	// operations
	// ==================================================
	typedef enum logic [4:0] {
		OP_NOP,
		// logic
		OP_OR,
		OP_AND,
		OP_NOR,
		OP_XOR,
		// shifts
		OP_SLL,
		OP_SRL,
		OP_SRA,
		// arithmetic and compare
		OP_ADD,
		OP_ADDU,
		OP_SUB,
		OP_SUBU,
		OP_SLT,
		OP_SLTU,
		OP_CLZ,
		OP_CLO,
		// hi/lo moves
		OP_MFHI,
		OP_MFLO,
		OP_MTHI,
		OP_MTLO,
		// multi-cycle, results land in hi/lo
		OP_MULT,
		OP_MULTU,
		OP_MADD,
		OP_MADDU,
		OP_MSUB,
		OP_MSUBU,
		OP_DIV,
		OP_DIVU
	} exec_op_e;

	typedef struct packed {
		exec_op_e                op;
		logic [WORD_W-1:0]       rs_val;
		logic [WORD_W-1:0]       rt_val;
		logic [REG_ADDR_W-1:0]   wd;
		logic                    wreg;
	} issue_t;

	typedef struct packed {
		logic [WORD_W-1:0]       wdata;
		logic [REG_ADDR_W-1:0]   wd;
		logic                    wreg;
		logic                    ov;
	} result_t;

	typedef struct packed {
		logic [WORD_W-1:0]       hi;
		logic [WORD_W-1:0]       lo;
	} hilo_t;

	// units produce the 64-bit whole, moves touch the halves
	typedef union packed {
		logic [2*WORD_W-1:0]     whole;
		hilo_t                   half;
	} hilo_u;

endpackage

//--- hdl/alu.sv
`timescale 1ns/100ps

module alu (
	input  exec_pkg::exec_op_e          op_i,
	input  logic [exec_pkg::WORD_W-1:0] a_i,
	input  logic [exec_pkg::WORD_W-1:0] b_i,
	output logic [exec_pkg::WORD_W-1:0] result_o,
	output logic                        ov_o
);

	logic                           sub_sel;
	logic [exec_pkg::WORD_W-1:0]    b_mux;
	logic [exec_pkg::WORD_W:0]      sum_ext;
	logic [exec_pkg::WORD_W-1:0]    sum;
	logic                           ov_raw;
	logic                           lt_signed;
	logic                           lt_unsigned;
	logic [exec_pkg::SHAMT_W-1:0]   shamt;
	logic [exec_pkg::WORD_W-1:0]    lead_src;
	logic [exec_pkg::WORD_W-1:0]    lead_cnt;

	function automatic logic [exec_pkg::WORD_W-1:0] count_lead_zeros(
		input logic [exec_pkg::WORD_W-1:0] v
	);
		logic [exec_pkg::WORD_W-1:0] n;
		logic                        hit;
		n   = '0;
		hit = 1'b0;
		for (int i = exec_pkg::WORD_W - 1; i >= 0; i--) begin
			if (v[i]) begin
				hit = 1'b1;
			end else if (!hit) begin
				n = n + 1;
			end
		end
		return n;
	endfunction

	// ==================================================
	// shared adder
	// ==================================================
	assign sub_sel = op_i inside {exec_pkg::OP_SUB, exec_pkg::OP_SUBU,
	                              exec_pkg::OP_SLT, exec_pkg::OP_SLTU};
	assign b_mux   = sub_sel ? ~b_i : b_i;
	// two's complement subtract via carry in
	assign sum_ext = {1'b0, a_i} + {1'b0, b_mux} + {{exec_pkg::WORD_W{1'b0}}, sub_sel};
	assign sum     = sum_ext[exec_pkg::WORD_W-1:0];

	// same-sign operands, result sign flipped
	assign ov_raw = (a_i[exec_pkg::WORD_W-1] == b_mux[exec_pkg::WORD_W-1]) &&
	                (sum[exec_pkg::WORD_W-1] != a_i[exec_pkg::WORD_W-1]);
	assign ov_o   = ov_raw && (op_i inside {exec_pkg::OP_ADD, exec_pkg::OP_SUB});

	// signs differ -> a is less when a is negative
	assign lt_signed   = (a_i[exec_pkg::WORD_W-1] != b_i[exec_pkg::WORD_W-1]) ?
	                     a_i[exec_pkg::WORD_W-1] : sum[exec_pkg::WORD_W-1];
	// no carry out of a + ~b + 1 means a borrow
	assign lt_unsigned = !sum_ext[exec_pkg::WORD_W];

	assign shamt    = a_i[exec_pkg::SHAMT_W-1:0];
	// clo counts zeros of the inverted operand
	assign lead_src = (op_i == exec_pkg::OP_CLO) ? ~a_i : a_i;
	assign lead_cnt = count_lead_zeros(lead_src);

	// ==================================================
	// result select
	// ==================================================
	always_comb begin
		case (op_i)
			exec_pkg::OP_OR:   result_o = a_i | b_i;
			exec_pkg::OP_AND:  result_o = a_i & b_i;
			exec_pkg::OP_NOR:  result_o = ~(a_i | b_i);
			exec_pkg::OP_XOR:  result_o = a_i ^ b_i;
			exec_pkg::OP_SLL:  result_o = b_i << shamt;
			exec_pkg::OP_SRL:  result_o = b_i >> shamt;
			exec_pkg::OP_SRA:  result_o = $signed(b_i) >>> shamt;
			exec_pkg::OP_ADD,
			exec_pkg::OP_ADDU,
			exec_pkg::OP_SUB,
			exec_pkg::OP_SUBU: result_o = sum;
			exec_pkg::OP_SLT:  result_o = {{(exec_pkg::WORD_W-1){1'b0}}, lt_signed};
			exec_pkg::OP_SLTU: result_o = {{(exec_pkg::WORD_W-1){1'b0}}, lt_unsigned};
			exec_pkg::OP_CLZ,
			exec_pkg::OP_CLO:  result_o = lead_cnt;
			default:           result_o = '0;
		endcase
	end

	// overflow is the carry into the sign bit differing from the carry out
	always_comb begin
		a_ov_carry: assert #0 (ov_o == ((op_i inside {exec_pkg::OP_ADD, exec_pkg::OP_SUB}) &&
			(sum_ext[exec_pkg::WORD_W] ^ a_i[exec_pkg::WORD_W-1] ^
			 b_mux[exec_pkg::WORD_W-1] ^ sum[exec_pkg::WORD_W-1])))
			else $error("overflow flag disagrees with the adder carries");
	end

endmodule

//--- hdl/mul_unit.sv
`timescale 1ns/100ps

module mul_unit (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic                        start_i,
	input  exec_pkg::exec_op_e          op_i,
	input  logic [exec_pkg::WORD_W-1:0] a_i,
	input  logic [exec_pkg::WORD_W-1:0] b_i,
	input  exec_pkg::hilo_u             acc_i,
	output logic                        done_o,
	output exec_pkg::hilo_u             hilo_o
);

	logic                            signed_op;
	logic                            acc_op;
	logic                            sub_op;
	logic [exec_pkg::WORD_W-1:0]     a_mag;
	logic [exec_pkg::WORD_W-1:0]     b_mag;
	logic [2*exec_pkg::WORD_W-1:0]   prod_mag;
	logic [2*exec_pkg::WORD_W-1:0]   prod;
	logic                            pend_q;
	logic                            sub_q;
	exec_pkg::hilo_u                 res_q;

	assign signed_op = op_i inside {exec_pkg::OP_MULT, exec_pkg::OP_MADD, exec_pkg::OP_MSUB};
	assign acc_op    = op_i inside {exec_pkg::OP_MADD, exec_pkg::OP_MADDU,
	                                exec_pkg::OP_MSUB, exec_pkg::OP_MSUBU};
	assign sub_op    = op_i inside {exec_pkg::OP_MSUB, exec_pkg::OP_MSUBU};

	// multiply magnitudes, fix the sign afterwards
	assign a_mag    = (signed_op && a_i[exec_pkg::WORD_W-1]) ? -a_i : a_i;
	assign b_mag    = (signed_op && b_i[exec_pkg::WORD_W-1]) ? -b_i : b_i;
	assign prod_mag = {{exec_pkg::WORD_W{1'b0}}, a_mag} * {{exec_pkg::WORD_W{1'b0}}, b_mag};
	assign prod     = (signed_op && (a_i[exec_pkg::WORD_W-1] ^ b_i[exec_pkg::WORD_W-1])) ?
	                  -prod_mag : prod_mag;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pend_q <= 1'b0;
			done_o <= 1'b0;
		end else begin
			pend_q <= start_i && acc_op;
			done_o <= (start_i && !acc_op) || pend_q;
		end
	end

	// product first, then hi/lo +/- product on the second edge
	always_ff @(posedge clk_i) begin
		if (start_i) begin
			res_q.whole <= prod;
			sub_q       <= sub_op;
		end else if (pend_q) begin
			res_q.whole <= sub_q ? (acc_i.whole - res_q.whole) : (acc_i.whole + res_q.whole);
		end
	end

	assign hilo_o = res_q;

	a_no_start_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pend_q |-> !start_i)
		else $error("multiply started while an accumulate is pending");

endmodule

//--- hdl/div_unit.sv
`timescale 1ns/100ps

module div_unit (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic                        start_i,
	input  logic                        signed_i,
	input  logic [exec_pkg::WORD_W-1:0] dividend_i,
	input  logic [exec_pkg::WORD_W-1:0] divisor_i,
	output logic                        done_o,
	output exec_pkg::hilo_u             hilo_o
);

	logic [exec_pkg::WORD_W-1:0]               a_mag;
	logic [exec_pkg::WORD_W-1:0]               b_mag;
	logic                                      run_q;
	logic [$clog2(exec_pkg::DIV_STEPS)-1:0]    cnt_q;
	logic                                      last_step;
	logic                                      q_neg_q;
	logic                                      r_neg_q;
	logic [exec_pkg::WORD_W-1:0]               quo_q;
	logic [exec_pkg::WORD_W-1:0]               rem_q;
	logic [exec_pkg::WORD_W-1:0]               dvs_q;
	logic [exec_pkg::WORD_W:0]                 rem_shift;
	logic [exec_pkg::WORD_W:0]                 diff;
	logic [exec_pkg::WORD_W-1:0]               quo_next;
	logic [exec_pkg::WORD_W-1:0]               rem_next;
	exec_pkg::hilo_u                           res_q;

	assign a_mag = (signed_i && dividend_i[exec_pkg::WORD_W-1]) ? -dividend_i : dividend_i;
	assign b_mag = (signed_i && divisor_i[exec_pkg::WORD_W-1]) ? -divisor_i : divisor_i;

	// ==================================================
	// one restoring step
	// ==================================================
	// shift next dividend bit into the partial remainder
	assign rem_shift = {rem_q, quo_q[exec_pkg::WORD_W-1]};
	assign diff      = rem_shift - {1'b0, dvs_q};
	// negative difference -> restore, quotient bit 0
	assign quo_next  = {quo_q[exec_pkg::WORD_W-2:0], !diff[exec_pkg::WORD_W]};
	assign rem_next  = diff[exec_pkg::WORD_W] ? rem_shift[exec_pkg::WORD_W-1:0] :
	                   diff[exec_pkg::WORD_W-1:0];

	assign last_step = (int'(cnt_q) == exec_pkg::DIV_STEPS - 1);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			run_q  <= 1'b0;
			cnt_q  <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= run_q && last_step;
			if (start_i) begin
				run_q <= 1'b1;
				cnt_q <= '0;
			end else if (run_q) begin
				cnt_q <= cnt_q + 1'b1;
				if (last_step) begin
					run_q <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_i) begin
			quo_q   <= a_mag;
			rem_q   <= '0;
			dvs_q   <= b_mag;
			q_neg_q <= signed_i && (dividend_i[exec_pkg::WORD_W-1] ^ divisor_i[exec_pkg::WORD_W-1]);
			r_neg_q <= signed_i && dividend_i[exec_pkg::WORD_W-1];
		end else if (run_q) begin
			quo_q <= quo_next;
			rem_q <= rem_next;
			// sign fix folded into the final step
			if (last_step) begin
				res_q.half.lo <= q_neg_q ? -quo_next : quo_next;
				res_q.half.hi <= r_neg_q ? -rem_next : rem_next;
			end
		end
	end

	assign hilo_o = res_q;

	// done follows its start by the full iteration count plus one
	a_done_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_o |-> $past(start_i, exec_pkg::DIV_STEPS + 1))
		else $error("divider done without a start DIV_STEPS+1 cycles earlier");

endmodule

//--- hdl/exec_ctrl.sv
`timescale 1ns/100ps

module exec_ctrl (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic                        issue_valid_i,
	input  exec_pkg::issue_t            issue_i,
	output logic                        issue_ready_o,
	output logic                        res_valid_o,
	output exec_pkg::result_t           res_o,
	output exec_pkg::exec_op_e          alu_op_o,
	output logic [exec_pkg::WORD_W-1:0] alu_a_o,
	output logic [exec_pkg::WORD_W-1:0] alu_b_o,
	input  logic [exec_pkg::WORD_W-1:0] alu_result_i,
	input  logic                        alu_ov_i,
	output logic                        mul_start_o,
	output exec_pkg::exec_op_e          mul_op_o,
	output exec_pkg::hilo_u             mul_acc_o,
	input  logic                        mul_done_i,
	input  exec_pkg::hilo_u             mul_hilo_i,
	output logic                        div_start_o,
	output logic                        div_signed_o,
	input  logic                        div_done_i,
	input  exec_pkg::hilo_u             div_hilo_i
);

	logic                              accept;
	logic                              is_mul;
	logic                              is_div;
	logic                              is_mt;
	logic                              busy_q;
	exec_pkg::exec_op_e                pend_op_q;
	logic [exec_pkg::REG_ADDR_W-1:0]   pend_wd_q;
	logic                              unit_done;
	exec_pkg::hilo_u                   unit_hilo;
	exec_pkg::hilo_u                   hilo_q;
	logic [exec_pkg::WORD_W-1:0]       imm_wdata;
	logic                              res_valid_q;
	exec_pkg::result_t                 res_q;

	assign issue_ready_o = !busy_q;
	assign accept        = issue_valid_i && issue_ready_o;

	assign is_mul = issue_i.op inside {exec_pkg::OP_MULT, exec_pkg::OP_MULTU,
	                                   exec_pkg::OP_MADD, exec_pkg::OP_MADDU,
	                                   exec_pkg::OP_MSUB, exec_pkg::OP_MSUBU};
	assign is_div = issue_i.op inside {exec_pkg::OP_DIV, exec_pkg::OP_DIVU};
	assign is_mt  = issue_i.op inside {exec_pkg::OP_MTHI, exec_pkg::OP_MTLO};

	// ==================================================
	// unit launch
	// ==================================================
	assign alu_op_o     = issue_i.op;
	assign alu_a_o      = issue_i.rs_val;
	assign alu_b_o      = issue_i.rt_val;
	assign mul_start_o  = accept && is_mul;
	assign mul_op_o     = issue_i.op;
	assign mul_acc_o    = hilo_q;
	assign div_start_o  = accept && is_div;
	assign div_signed_o = (issue_i.op == exec_pkg::OP_DIV);

	// listen only to the unit that was launched
	assign unit_done = (pend_op_q inside {exec_pkg::OP_DIV, exec_pkg::OP_DIVU}) ?
	                   div_done_i : mul_done_i;
	assign unit_hilo = (pend_op_q inside {exec_pkg::OP_DIV, exec_pkg::OP_DIVU}) ?
	                   div_hilo_i : mul_hilo_i;

	always_comb begin
		case (issue_i.op)
			exec_pkg::OP_MFHI: imm_wdata = hilo_q.half.hi;
			exec_pkg::OP_MFLO: imm_wdata = hilo_q.half.lo;
			default:           imm_wdata = alu_result_i;
		endcase
	end

	// ==================================================
	// busy, hi/lo and result valid
	// ==================================================
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q      <= 1'b0;
			pend_op_q   <= exec_pkg::OP_NOP;
			res_valid_q <= 1'b0;
			hilo_q      <= '0;
		end else begin
			res_valid_q <= 1'b0;
			if (busy_q) begin
				if (unit_done) begin
					busy_q      <= 1'b0;
					res_valid_q <= 1'b1;
					hilo_q      <= unit_hilo;
				end
			end else if (accept) begin
				if (is_mul || is_div) begin
					busy_q    <= 1'b1;
					pend_op_q <= issue_i.op;
				end else begin
					res_valid_q <= 1'b1;
					if (issue_i.op == exec_pkg::OP_MTHI) begin
						hilo_q.half.hi <= issue_i.rs_val;
					end
					if (issue_i.op == exec_pkg::OP_MTLO) begin
						hilo_q.half.lo <= issue_i.rs_val;
					end
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (busy_q && unit_done) begin
			// hi/lo producers never write the register file
			res_q.wdata <= '0;
			res_q.wd    <= pend_wd_q;
			res_q.wreg  <= 1'b0;
			res_q.ov    <= 1'b0;
		end else if (accept) begin
			pend_wd_q   <= issue_i.wd;
			res_q.wdata <= imm_wdata;
			res_q.wd    <= issue_i.wd;
			// add/sub overflow drops the write
			res_q.wreg  <= issue_i.wreg && !alu_ov_i && !is_mt;
			res_q.ov    <= alu_ov_i;
		end
	end

	assign res_valid_o = res_valid_q;
	assign res_o       = res_q;

	// a unit may only finish an operation that was launched
	a_done_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(mul_done_i || div_done_i) |-> busy_q)
		else $error("unit done with no multi-cycle operation pending");

endmodule

//--- hdl/exec_stage.sv
`timescale 1ns/100ps

module exec_stage (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              issue_valid_i,
	input  exec_pkg::issue_t  issue_i,
	output logic              issue_ready_o,
	output logic              res_valid_o,
	output exec_pkg::result_t res_o
);

	exec_pkg::exec_op_e            alu_op;
	logic [exec_pkg::WORD_W-1:0]   alu_a;
	logic [exec_pkg::WORD_W-1:0]   alu_b;
	logic [exec_pkg::WORD_W-1:0]   alu_result;
	logic                          alu_ov;
	logic                          mul_start;
	exec_pkg::exec_op_e            mul_op;
	exec_pkg::hilo_u               mul_acc;
	logic                          mul_done;
	exec_pkg::hilo_u               mul_hilo;
	logic                          div_start;
	logic                          div_signed;
	logic                          div_done;
	exec_pkg::hilo_u               div_hilo;

	exec_ctrl u_exec_ctrl (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.issue_valid_i (issue_valid_i),
		.issue_i       (issue_i),
		.issue_ready_o (issue_ready_o),
		.res_valid_o   (res_valid_o),
		.res_o         (res_o),
		.alu_op_o      (alu_op),
		.alu_a_o       (alu_a),
		.alu_b_o       (alu_b),
		.alu_result_i  (alu_result),
		.alu_ov_i      (alu_ov),
		.mul_start_o   (mul_start),
		.mul_op_o      (mul_op),
		.mul_acc_o     (mul_acc),
		.mul_done_i    (mul_done),
		.mul_hilo_i    (mul_hilo),
		.div_start_o   (div_start),
		.div_signed_o  (div_signed),
		.div_done_i    (div_done),
		.div_hilo_i    (div_hilo)
	);

	alu u_alu (
		.op_i     (alu_op),
		.a_i      (alu_a),
		.b_i      (alu_b),
		.result_o (alu_result),
		.ov_o     (alu_ov)
	);

	// sequential units share the alu operand wires
	mul_unit u_mul_unit (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.start_i (mul_start),
		.op_i    (mul_op),
		.a_i     (alu_a),
		.b_i     (alu_b),
		.acc_i   (mul_acc),
		.done_o  (mul_done),
		.hilo_o  (mul_hilo)
	);

	div_unit u_div_unit (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.start_i    (div_start),
		.signed_i   (div_signed),
		.dividend_i (alu_a),
		.divisor_i  (alu_b),
		.done_o     (div_done),
		.hilo_o     (div_hilo)
	);

endmodule

//--- tb/tb_exec_stage.sv
`timescale 1ns/100ps

module tb_exec_stage;

	logic                           clk;
	logic                           rst_n;
	logic                           issue_valid;
	exec_pkg::issue_t               issue;
	logic                           issue_ready;
	logic                           res_valid;
	exec_pkg::result_t              res;

	integer                         seed;
	logic [exec_pkg::WORD_W-1:0]    model_hi;
	logic [exec_pkg::WORD_W-1:0]    model_lo;
	exec_pkg::result_t              exp_q[$];
	exec_pkg::result_t              exp_cur;
	logic                           chk_valid;
	logic                           extra_res;
	logic                           multi_acc;
	logic                           single_acc;

	exec_stage u_exec_stage (
		.clk_i         (clk),
		.rst_n_i       (rst_n),
		.issue_valid_i (issue_valid),
		.issue_i       (issue),
		.issue_ready_o (issue_ready),
		.res_valid_o   (res_valid),
		.res_o         (res)
	);

	always #4 clk = ~clk;

	task automatic report_mismatch(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	function automatic logic [31:0] leading_count(input logic [31:0] v, input logic bit_val);
		logic [31:0] n;
		logic        run;
		n   = '0;
		run = 1'b1;
		for (int i = 31; i >= 0; i--) begin
			if (run && v[i] == bit_val) begin
				n = n + 32'd1;
			end else begin
				run = 1'b0;
			end
		end
		return n;
	endfunction

	// ==================================================
	// reference model
	// ==================================================
	task automatic model_op(input exec_pkg::issue_t op_s);
		exec_pkg::result_t exp;
		logic [31:0]       rs;
		logic [31:0]       rt;
		logic [63:0]       prod;
		logic [31:0]       a_mag;
		logic [31:0]       b_mag;
		logic [31:0]       q_mag;
		logic [31:0]       r_mag;
		logic              sgn;
		longint            s;
		rs        = op_s.rs_val;
		rt        = op_s.rt_val;
		exp.wdata = '0;
		exp.wd    = op_s.wd;
		exp.wreg  = op_s.wreg;
		exp.ov    = 1'b0;
		case (op_s.op)
			exec_pkg::OP_OR:   exp.wdata = rs | rt;
			exec_pkg::OP_AND:  exp.wdata = rs & rt;
			exec_pkg::OP_NOR:  exp.wdata = ~(rs | rt);
			exec_pkg::OP_XOR:  exp.wdata = rs ^ rt;
			exec_pkg::OP_SLL:  exp.wdata = rt << rs[4:0];
			exec_pkg::OP_SRL:  exp.wdata = rt >> rs[4:0];
			exec_pkg::OP_SRA:  exp.wdata = $unsigned($signed(rt) >>> rs[4:0]);
			exec_pkg::OP_ADDU: exp.wdata = rs + rt;
			exec_pkg::OP_SUBU: exp.wdata = rs - rt;
			exec_pkg::OP_ADD, exec_pkg::OP_SUB: begin
				if (op_s.op == exec_pkg::OP_ADD) begin
					s = longint'($signed(rs)) + longint'($signed(rt));
				end else begin
					s = longint'($signed(rs)) - longint'($signed(rt));
				end
				exp.wdata = s[31:0];
				// out of the signed 32-bit range means no register write
				exp.ov    = (s > 64'sd2147483647) || (s < -64'sd2147483648);
				exp.wreg  = op_s.wreg && !exp.ov;
			end
			exec_pkg::OP_SLT:  exp.wdata = {31'b0, $signed(rs) < $signed(rt)};
			exec_pkg::OP_SLTU: exp.wdata = {31'b0, rs < rt};
			exec_pkg::OP_CLZ:  exp.wdata = leading_count(rs, 1'b0);
			exec_pkg::OP_CLO:  exp.wdata = leading_count(rs, 1'b1);
			exec_pkg::OP_MFHI: exp.wdata = model_hi;
			exec_pkg::OP_MFLO: exp.wdata = model_lo;
			exec_pkg::OP_MTHI, exec_pkg::OP_MTLO: begin
				exp.wreg = 1'b0;
				if (op_s.op == exec_pkg::OP_MTHI) begin
					model_hi = rs;
				end else begin
					model_lo = rs;
				end
			end
			exec_pkg::OP_DIV, exec_pkg::OP_DIVU: begin
				exp.wreg = 1'b0;
				sgn      = (op_s.op == exec_pkg::OP_DIV);
				a_mag    = (sgn && rs[31]) ? -rs : rs;
				b_mag    = (sgn && rt[31]) ? -rt : rt;
				if (b_mag == 32'd0) begin
					q_mag = '1;
					r_mag = a_mag;
				end else begin
					q_mag = a_mag / b_mag;
					r_mag = a_mag % b_mag;
				end
				model_lo = (sgn && (rs[31] ^ rt[31])) ? -q_mag : q_mag;
				model_hi = (sgn && rs[31]) ? -r_mag : r_mag;
			end
			default: begin
				// the multiply family, everything else is covered above
				exp.wreg = 1'b0;
				if (op_s.op inside {exec_pkg::OP_MULT, exec_pkg::OP_MADD, exec_pkg::OP_MSUB}) begin
					prod = $signed({{32{rs[31]}}, rs}) * $signed({{32{rt[31]}}, rt});
				end else begin
					prod = {32'b0, rs} * {32'b0, rt};
				end
				if (op_s.op inside {exec_pkg::OP_MADD, exec_pkg::OP_MADDU}) begin
					prod = {model_hi, model_lo} + prod;
				end else if (op_s.op inside {exec_pkg::OP_MSUB, exec_pkg::OP_MSUBU}) begin
					prod = {model_hi, model_lo} - prod;
				end
				{model_hi, model_lo} = prod;
			end
		endcase
		exp_q.push_back(exp);
	endtask

	// drives at a rising edge and returns at the accepting edge, valid left high
	task automatic send_op(input exec_pkg::exec_op_e op, input logic [31:0] rs,
	                       input logic [31:0] rt, input logic [4:0] wd, input logic wreg);
		exec_pkg::issue_t op_s;
		int               waited;
		op_s.op     = op;
		op_s.rs_val = rs;
		op_s.rt_val = rt;
		op_s.wd     = wd;
		op_s.wreg   = wreg;
		issue_valid <= 1'b1;
		issue       <= op_s;
		waited      = 0;
		@(negedge clk);
		while (!issue_ready) begin
			waited++;
			if (waited > 200) begin
				report_failure("timeout: issue_ready_o stayed low for a held operation");
			end
			@(negedge clk);
		end
		model_op(op_s);
		@(posedge clk);
	endtask

	task automatic read_hilo(input logic [4:0] wd);
		send_op(exec_pkg::OP_MFHI, 32'd0, 32'd0, wd, 1'b1);
		send_op(exec_pkg::OP_MFLO, 32'd0, 32'd0, wd + 5'd1, 1'b1);
	endtask

	// ==================================================
	// result checks
	// ==================================================
	always @(negedge clk) begin
		chk_valid = 1'b0;
		extra_res = 1'b0;
		if (rst_n && res_valid) begin
			if (exp_q.size() == 0) begin
				extra_res = 1'b1;
			end else begin
				exp_cur   = exp_q.pop_front();
				chk_valid = 1'b1;
			end
		end
	end

	assign multi_acc  = issue_valid && issue_ready && (issue.op inside {
		exec_pkg::OP_MULT, exec_pkg::OP_MULTU, exec_pkg::OP_MADD, exec_pkg::OP_MADDU,
		exec_pkg::OP_MSUB, exec_pkg::OP_MSUBU, exec_pkg::OP_DIV, exec_pkg::OP_DIVU});
	assign single_acc = issue_valid && issue_ready && !multi_acc;

	a_res_match: assert property (@(posedge clk) disable iff (!rst_n)
		chk_valid |-> (res == exp_cur))
		else report_mismatch($sformatf("res_o differs from model, expected %h", exp_cur));

	a_no_extra: assert property (@(posedge clk) disable iff (!rst_n) !extra_res)
		else report_failure("a result retired with no operation outstanding");

	a_alu_next: assert property (@(posedge clk) disable iff (!rst_n)
		single_acc |=> res_valid)
		else report_failure("single-cycle operation did not retire on the next edge");

	a_multi_stall: assert property (@(posedge clk) disable iff (!rst_n)
		multi_acc |=> !issue_ready)
		else report_failure("issue_ready_o stayed high after a multi-cycle launch");

	a_ready_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(issue_ready) |-> res_valid)
		else report_failure("issue_ready_o returned without a result");

	// ==================================================
	// stimulus
	// ==================================================
	initial begin
		logic [31:0]        r_op;
		logic [31:0]        r_wd;
		int                 waited;
		clk         = 1'b0;
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		issue       = '0;
		seed        = 32'h9124_9aca;
		model_hi    = '0;
		model_lo    = '0;
		chk_valid   = 1'b0;
		extra_res   = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		a_reset_state: assert (issue_ready && !res_valid)
			else report_mismatch("ready low or result valid after reset");
		@(posedge clk);

		// logic, shifts, compares and leading counts, back to back
		send_op(exec_pkg::OP_OR,   32'hf0f0_1234, 32'h0f0f_4321, 5'd1, 1'b1);
		send_op(exec_pkg::OP_AND,  32'hffff_ffff, 32'h5a5a_a5a5, 5'd2, 1'b1);
		send_op(exec_pkg::OP_NOR,  32'h0000_0000, 32'h0000_0000, 5'd3, 1'b1);
		send_op(exec_pkg::OP_XOR,  32'hffff_ffff, 32'h1234_5678, 5'd4, 1'b1);
		send_op(exec_pkg::OP_SLL,  32'd4,         32'h8000_0001, 5'd5, 1'b1);
		send_op(exec_pkg::OP_SRL,  32'd31,        32'h8000_0000, 5'd6, 1'b1);
		send_op(exec_pkg::OP_SRA,  32'd4,         32'h8000_00f0, 5'd7, 1'b1);
		send_op(exec_pkg::OP_SRA,  32'd31,        32'hffff_0000, 5'd8, 1'b0);
		send_op(exec_pkg::OP_SLT,  32'hffff_ffff, 32'd1,         5'd9, 1'b1);
		send_op(exec_pkg::OP_SLTU, 32'hffff_ffff, 32'd1,         5'd10, 1'b1);
		send_op(exec_pkg::OP_CLZ,  32'h0000_0000, 32'd0,         5'd11, 1'b1);
		send_op(exec_pkg::OP_CLZ,  32'h0000_1000, 32'd0,         5'd12, 1'b1);
		send_op(exec_pkg::OP_CLO,  32'hffff_ffff, 32'd0,         5'd13, 1'b1);
		send_op(exec_pkg::OP_CLO,  32'hfff0_0000, 32'd0,         5'd14, 1'b1);

		// overflow drops the write only for the signed forms
		send_op(exec_pkg::OP_ADD,  32'h7fff_ffff, 32'd1,         5'd15, 1'b1);
		send_op(exec_pkg::OP_ADDU, 32'h7fff_ffff, 32'd1,         5'd15, 1'b1);
		send_op(exec_pkg::OP_SUB,  32'h8000_0000, 32'd1,         5'd16, 1'b1);
		send_op(exec_pkg::OP_SUBU, 32'h8000_0000, 32'd1,         5'd16, 1'b1);
		send_op(exec_pkg::OP_ADD,  32'h8000_0000, 32'hffff_ffff, 5'd17, 1'b1);
		send_op(exec_pkg::OP_SUB,  32'h0000_0005, 32'h0000_0007, 5'd17, 1'b1);

		// seed hi/lo, then each multiply form is read back straight away
		send_op(exec_pkg::OP_MTHI, 32'h1234_5678, 32'd0, 5'd0, 1'b1);
		send_op(exec_pkg::OP_MTLO, 32'h9abc_def0, 32'd0, 5'd0, 1'b1);
		read_hilo(5'd20);
		send_op(exec_pkg::OP_MULT,  32'hffff_fff6, 32'h0000_0007, 5'd21, 1'b1);
		read_hilo(5'd22);
		send_op(exec_pkg::OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, 5'd21, 1'b1);
		read_hilo(5'd22);
		send_op(exec_pkg::OP_MADD,  32'hffff_fffd, 32'h0000_0005, 5'd21, 1'b1);
		read_hilo(5'd22);
		send_op(exec_pkg::OP_MADDU, 32'h8000_0000, 32'h0000_0004, 5'd21, 1'b1);
		read_hilo(5'd22);
		send_op(exec_pkg::OP_MSUB,  32'hffff_fffe, 32'hffff_fff7, 5'd21, 1'b1);
		read_hilo(5'd22);
		send_op(exec_pkg::OP_MSUBU, 32'h0000_1234, 32'h0000_5678, 5'd21, 1'b1);
		read_hilo(5'd22);

		// mixed signs, zero divisor and the most negative dividend
		send_op(exec_pkg::OP_DIV,  32'hffff_fff9, 32'h0000_0002, 5'd24, 1'b1);
		read_hilo(5'd25);
		send_op(exec_pkg::OP_DIV,  32'h0000_0007, 32'hffff_fffe, 5'd24, 1'b1);
		read_hilo(5'd25);
		send_op(exec_pkg::OP_DIV,  32'hffff_fff9, 32'hffff_fffe, 5'd24, 1'b1);
		read_hilo(5'd25);
		send_op(exec_pkg::OP_DIVU, 32'hffff_fff9, 32'h0000_0002, 5'd24, 1'b1);
		read_hilo(5'd25);
		send_op(exec_pkg::OP_DIV,  32'hffff_ff00, 32'h0000_0000, 5'd24, 1'b1);
		read_hilo(5'd25);
		send_op(exec_pkg::OP_DIVU, 32'h8765_4321, 32'h0000_0000, 5'd24, 1'b1);
		read_hilo(5'd25);
		send_op(exec_pkg::OP_DIV,  32'h8000_0000, 32'hffff_ffff, 5'd24, 1'b1);
		read_hilo(5'd25);

		// random mix over every kept opcode
		for (int n = 0; n < 80; n++) begin
			r_op = $random(seed);
			r_wd = $random(seed);
			send_op(exec_pkg::exec_op_e'(5'd1 + 5'(r_op % 32'd27)), $random(seed),
			        $random(seed), r_wd[4:0], r_wd[8]);
		end

		issue_valid <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (exp_q.size() != 0) begin
			waited++;
			if (waited > 200) begin
				report_failure("timeout: outstanding results never retired");
			end
			@(negedge clk);
		end
		// let the last compare run
		repeat (2) @(posedge clk);
		$display("all tests passed");
		$finish;
	end

endmodule

//--- sources.f
hdl/exec_pkg.sv
hdl/alu.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/exec_ctrl.sv
hdl/exec_stage.sv
tb/tb_exec_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_exec_stage -Mdir obj_dir

# the simulator exit status is ignored here, the log decides
./obj_dir/Vtb_exec_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL"
	exit 1
fi
